/* fifo_wr_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface fifo_wr_if #(
    parameter int WIDTH = 32
);

    logic [WIDTH-1:0] data;
    logic             valid;
    logic             ready;
    // entries currently held, zero-extended
    logic [31:0]      occup;

    modport producer (output data, output valid, input ready, input occup);
    modport queue (input data, input valid, output ready, output occup);

endinterface

`default_nettype wire

/* pdu_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pdu_settings.svh"

module pdu_gen
    import pdu_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  var flit_t                   in_flit,
    input  logic [`PDU_EMPTY_WIDTH-1:0] in_empty,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  var metadata_t               in_meta,
    input  logic                        in_meta_valid,
    output logic                        in_meta_ready,
    output var flit_t                   out_flit,
    output logic                        out_flit_valid,
    input  logic                        out_flit_ready,
    output var pkt_desc_t               out_desc,
    output logic                        out_desc_valid,
    input  logic                        out_desc_ready
);

    localparam logic [31:0] PKT_Q_AF_LEVEL  = 32'(`PDU_PKT_Q_DEPTH - `PDU_Q_SLACK);
    localparam logic [31:0] DESC_Q_AF_LEVEL = 32'(`PDU_META_Q_DEPTH - `PDU_Q_SLACK);

    fifo_wr_if #(.WIDTH($bits(flit_t)))     pkt_wr ();
    fifo_wr_if #(.WIDTH($bits(pkt_desc_t))) desc_wr ();

    metadata_t meta_r;
    metadata_t meta_sel;
    logic      needs_meta;
    logic      almost_full;
    logic      meta_xfer;
    logic      flit_xfer;

    logic [`PDU_FLIT_WIDTH-1:0] data_swap;
    logic [`PDU_SIZE_WIDTH-1:0] flit_cnt;
    logic [`PDU_SIZE_WIDTH-1:0] byte_cnt;
    logic [`PDU_SIZE_WIDTH-1:0] flit_cnt_next;
    logic [`PDU_SIZE_WIDTH-1:0] byte_cnt_next;

    flit_t     pkt_wr_data;
    logic      pkt_wr_valid;
    pkt_desc_t desc_wr_data;
    logic      desc_wr_valid;

    // input is held off while either queue could overflow
    assign almost_full = (pkt_wr.occup > PKT_Q_AF_LEVEL) |
                         (desc_wr.occup > DESC_Q_AF_LEVEL);

    assign in_meta_ready = ~almost_full & needs_meta;

    // a flit needs metadata already held or arriving in the same cycle
    assign in_ready = ~almost_full & (~needs_meta | (in_meta_valid & in_meta_ready));

    assign meta_xfer = in_meta_valid & in_meta_ready;
    assign flit_xfer = in_valid & in_ready;

    // metadata that arrives with the first flit is used directly
    assign meta_sel = needs_meta ? in_meta : meta_r;

    // byte i of the output takes byte 63 - i of the input
    always_comb begin
        for (int i = 0; i < `PDU_FLIT_BYTES; i++) begin
            data_swap[i*8 +: 8] = in_flit.data[(`PDU_FLIT_BYTES-1-i)*8 +: 8];
        end
    end

    // counts restart on sop, last flit loses its empty bytes
    always_comb begin
        flit_cnt_next = (in_flit.sop ? '0 : flit_cnt) + 1'b1;
        byte_cnt_next = (in_flit.sop ? '0 : byte_cnt) + `PDU_SIZE_WIDTH'(`PDU_FLIT_BYTES);
        if (in_flit.eop) begin
            byte_cnt_next = byte_cnt_next - `PDU_SIZE_WIDTH'(in_empty);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            needs_meta <= 1'b1;
        end else if (flit_xfer & in_flit.eop) begin
            needs_meta <= 1'b1;
        end else if (meta_xfer) begin
            needs_meta <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (meta_xfer) begin
            meta_r <= in_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flit_cnt <= '0;
            byte_cnt <= '0;
        end else if (flit_xfer) begin
            flit_cnt <= flit_cnt_next;
            byte_cnt <= byte_cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_wr_valid  <= 1'b0;
            desc_wr_valid <= 1'b0;
        end else begin
            pkt_wr_valid  <= flit_xfer;
            desc_wr_valid <= flit_xfer & in_flit.eop;
        end
    end

    always_ff @(posedge clk) begin
        if (flit_xfer) begin
            pkt_wr_data.sop  <= in_flit.sop;
            pkt_wr_data.eop  <= in_flit.eop;
            pkt_wr_data.data <= data_swap;
        end
        if (flit_xfer & in_flit.eop) begin
            desc_wr_data.dsc_queue_id <= meta_sel.dsc_queue_id[`PDU_APP_IDX_WIDTH-1:0];
            desc_wr_data.pkt_queue_id <= meta_sel.pkt_queue_id[`PDU_FLOW_IDX_WIDTH-1:0];
            desc_wr_data.size_flits   <= flit_cnt_next;
            desc_wr_data.size_bytes   <= byte_cnt_next;
        end
    end

    assign pkt_wr.data   = pkt_wr_data;
    assign pkt_wr.valid  = pkt_wr_valid;
    assign desc_wr.data  = desc_wr_data;
    assign desc_wr.valid = desc_wr_valid;

    sync_fifo #(
        .WIDTH ($bits(flit_t)),
        .DEPTH (`PDU_PKT_Q_DEPTH)
    ) pkt_queue (
        .clk       (clk),
        .rst       (rst),
        .wr        (pkt_wr),
        .out_data  (out_flit),
        .out_valid (out_flit_valid),
        .out_ready (out_flit_ready)
    );

    sync_fifo #(
        .WIDTH ($bits(pkt_desc_t)),
        .DEPTH (`PDU_META_Q_DEPTH)
    ) desc_queue (
        .clk       (clk),
        .rst       (rst),
        .wr        (desc_wr),
        .out_data  (out_desc),
        .out_valid (out_desc_valid),
        .out_ready (out_desc_ready)
    );

endmodule

`default_nettype wire

/* pdu_pkg.sv */
`default_nettype none

`include "pdu_settings.svh"

package pdu_pkg;

    // one per packet, names the flow queue and the descriptor queue
    typedef struct packed {
        logic [15:0] pkt_queue_id;
        logic [15:0] dsc_queue_id;
    } metadata_t;

    typedef struct packed {
        logic                       sop;
        logic                       eop;
        logic [`PDU_FLIT_WIDTH-1:0] data;
    } flit_t;

    // written once per packet at eop
    typedef struct packed {
        logic [`PDU_APP_IDX_WIDTH-1:0]  dsc_queue_id;
        logic [`PDU_FLOW_IDX_WIDTH-1:0] pkt_queue_id;
        logic [`PDU_SIZE_WIDTH-1:0]     size_flits;
        logic [`PDU_SIZE_WIDTH-1:0]     size_bytes;
    } pkt_desc_t;

endpackage

`default_nettype wire

/* pdu_settings.svh */
`ifndef PDU_SETTINGS_SVH
`define PDU_SETTINGS_SVH

// flit geometry
`define PDU_FLIT_BYTES 64
`define PDU_FLIT_WIDTH (`PDU_FLIT_BYTES * 8)
`define PDU_EMPTY_WIDTH 6

// queue indices kept in the descriptor
`define PDU_FLOW_IDX_WIDTH 8
`define PDU_APP_IDX_WIDTH 4

// descriptor length fields
`define PDU_SIZE_WIDTH 16

// output queue depths
`define PDU_PKT_Q_DEPTH 64
`define PDU_META_Q_DEPTH 16

// free entries left for the write still in flight
`define PDU_Q_SLACK 2

`endif

/* pdu_top.f */
+incdir+.
pdu_pkg.sv
fifo_wr_if.sv
sync_fifo.sv
pdu_gen.sv
pdu_top.sv
pdu_top_assert.sv
tb_pdu_top.sv

/* pdu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pdu_settings.svh"

module pdu_top
    import pdu_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_sop,
    input  logic                          in_eop,
    input  logic [`PDU_FLIT_WIDTH-1:0]    in_data,
    input  logic [`PDU_EMPTY_WIDTH-1:0]   in_empty,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [15:0]                   in_meta_pkt_queue_id,
    input  logic [15:0]                   in_meta_dsc_queue_id,
    input  logic                          in_meta_valid,
    output logic                          in_meta_ready,
    output logic                          out_pkt_sop,
    output logic                          out_pkt_eop,
    output logic [`PDU_FLIT_WIDTH-1:0]    out_pkt_data,
    output logic                          out_pkt_valid,
    input  logic                          out_pkt_ready,
    output logic [`PDU_APP_IDX_WIDTH-1:0]  out_dsc_queue_id,
    output logic [`PDU_FLOW_IDX_WIDTH-1:0] out_pkt_queue_id,
    output logic [`PDU_SIZE_WIDTH-1:0]    out_size_flits,
    output logic [`PDU_SIZE_WIDTH-1:0]    out_size_bytes,
    output logic                          out_dsc_valid,
    input  logic                          out_dsc_ready
);

    flit_t     in_flit;
    metadata_t in_meta;
    flit_t     out_flit;
    pkt_desc_t out_desc;

    // pack the flat input ports
    assign in_flit.sop  = in_sop;
    assign in_flit.eop  = in_eop;
    assign in_flit.data = in_data;

    assign in_meta.pkt_queue_id = in_meta_pkt_queue_id;
    assign in_meta.dsc_queue_id = in_meta_dsc_queue_id;

    // unpack the queue heads
    assign out_pkt_sop  = out_flit.sop;
    assign out_pkt_eop  = out_flit.eop;
    assign out_pkt_data = out_flit.data;

    assign out_dsc_queue_id = out_desc.dsc_queue_id;
    assign out_pkt_queue_id = out_desc.pkt_queue_id;
    assign out_size_flits   = out_desc.size_flits;
    assign out_size_bytes   = out_desc.size_bytes;

    pdu_gen u_pdu_gen (
        .clk            (clk),
        .rst            (rst),
        .in_flit        (in_flit),
        .in_empty       (in_empty),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_meta        (in_meta),
        .in_meta_valid  (in_meta_valid),
        .in_meta_ready  (in_meta_ready),
        .out_flit       (out_flit),
        .out_flit_valid (out_pkt_valid),
        .out_flit_ready (out_pkt_ready),
        .out_desc       (out_desc),
        .out_desc_valid (out_dsc_valid),
        .out_desc_ready (out_dsc_ready)
    );

endmodule

`default_nettype wire

/* pdu_top_assert.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pdu_settings.svh"

module pdu_top_assert (
    input logic                           clk,
    input logic                           rst,
    input logic                           out_pkt_sop,
    input logic                           out_pkt_eop,
    input logic [`PDU_FLIT_WIDTH-1:0]     out_pkt_data,
    input logic                           out_pkt_valid,
    input logic                           out_pkt_ready,
    input logic [`PDU_APP_IDX_WIDTH-1:0]  out_dsc_queue_id,
    input logic [`PDU_FLOW_IDX_WIDTH-1:0] out_pkt_queue_id,
    input logic [`PDU_SIZE_WIDTH-1:0]     out_size_flits,
    input logic [`PDU_SIZE_WIDTH-1:0]     out_size_bytes,
    input logic                           out_dsc_valid,
    input logic                           out_dsc_ready
);

    logic [`PDU_FLIT_WIDTH+1:0] pkt_word;
    logic [`PDU_APP_IDX_WIDTH+`PDU_FLOW_IDX_WIDTH+2*`PDU_SIZE_WIDTH-1:0] dsc_word;

    assign pkt_word = {out_pkt_sop, out_pkt_eop, out_pkt_data};
    assign dsc_word = {out_dsc_queue_id, out_pkt_queue_id, out_size_flits, out_size_bytes};

    // a stalled head stays put until it is taken
    pkt_hold: assert property (@(posedge clk) disable iff (rst)
        out_pkt_valid && !out_pkt_ready |=> out_pkt_valid && $stable(pkt_word))
        else $error("packet output dropped or changed while stalled");

    dsc_hold: assert property (@(posedge clk) disable iff (rst)
        out_dsc_valid && !out_dsc_ready |=> out_dsc_valid && $stable(dsc_word))
        else $error("descriptor output dropped or changed while stalled");

    reset_idle: assert property (@(posedge clk) rst |=> !out_pkt_valid && !out_dsc_valid)
        else $error("output valid high right after reset");

endmodule

bind pdu_top pdu_top_assert u_pdu_top_assert (
    .clk              (clk),
    .rst              (rst),
    .out_pkt_sop      (out_pkt_sop),
    .out_pkt_eop      (out_pkt_eop),
    .out_pkt_data     (out_pkt_data),
    .out_pkt_valid    (out_pkt_valid),
    .out_pkt_ready    (out_pkt_ready),
    .out_dsc_queue_id (out_dsc_queue_id),
    .out_pkt_queue_id (out_pkt_queue_id),
    .out_size_flits   (out_size_flits),
    .out_size_bytes   (out_size_bytes),
    .out_dsc_valid    (out_dsc_valid),
    .out_dsc_ready    (out_dsc_ready)
);

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f pdu_top.f \
    --top-module tb_pdu_top \
    -o sim_pdu_top

# the simulator returns non-zero after $fatal, the verdict comes from the output
output=$(./obj_dir/sim_pdu_top 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* sync_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    fifo_wr_if.queue         wr,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr.ready = (count != CNT_W'(DEPTH));
    assign wr.occup = 32'(count);

    // show-ahead, head entry is visible whenever the queue is not empty
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign do_wr = wr.valid & wr.ready;
    assign do_rd = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
        end
    end

    // simultaneous read and write leaves the count alone
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({do_wr, do_rd})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb_pdu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pdu_settings.svh"

module tb_pdu_top;

    localparam int NUM_PKTS        = 200;
    localparam int MAX_FLITS       = 8;
    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_CYCLES = NUM_PKTS * MAX_FLITS * 6;
    localparam int FLIT_W          = `PDU_FLIT_WIDTH;
    localparam int FLIT_BYTES      = `PDU_FLIT_BYTES;
    localparam int DESC_W = `PDU_APP_IDX_WIDTH + `PDU_FLOW_IDX_WIDTH + 2 * `PDU_SIZE_WIDTH;

    logic                                 clk = 1'b0;
    logic                                 rst = 1'b1;
    logic                                 in_sop = 1'b0;
    logic                                 in_eop = 1'b0;
    logic [FLIT_W-1:0]                    in_data = '0;
    logic [`PDU_EMPTY_WIDTH-1:0]          in_empty = '0;
    logic                                 in_valid = 1'b0;
    logic                                 in_ready;
    logic [15:0]                          in_meta_pkt_queue_id = '0;
    logic [15:0]                          in_meta_dsc_queue_id = '0;
    logic                                 in_meta_valid = 1'b0;
    logic                                 in_meta_ready;
    logic                                 out_pkt_sop;
    logic                                 out_pkt_eop;
    logic [FLIT_W-1:0]                    out_pkt_data;
    logic                                 out_pkt_valid;
    logic                                 out_pkt_ready = 1'b0;
    logic [`PDU_APP_IDX_WIDTH-1:0]        out_dsc_queue_id;
    logic [`PDU_FLOW_IDX_WIDTH-1:0]       out_pkt_queue_id;
    logic [`PDU_SIZE_WIDTH-1:0]           out_size_flits;
    logic [`PDU_SIZE_WIDTH-1:0]           out_size_bytes;
    logic                                 out_dsc_valid;
    logic                                 out_dsc_ready = 1'b0;

    // per-packet stimulus drawn before the run
    logic [15:0]                 pkt_ids [NUM_PKTS];
    logic [15:0]                 dsc_ids [NUM_PKTS];
    int                          pkt_len [NUM_PKTS];
    logic [`PDU_EMPTY_WIDTH-1:0] pkt_empty [NUM_PKTS];

    // reference model
    logic [FLIT_W+1:0] exp_flits [$];
    logic [DESC_W-1:0] exp_descs [$];
    bit                meta_held = 1'b0;
    logic [15:0]       held_pkt_id;
    logic [15:0]       held_dsc_id;
    int                model_flits = 0;
    bit                flit_acc;
    bit                meta_acc;
    bit                saw_in_stall = 1'b0;
    int                flits_out = 0;
    int                descs_out = 0;
    int                total_flits = 0;

    int drv_pkt = 0;
    int drv_flit = 0;
    int meta_idx = 0;
    int stall_left = 0;

    pdu_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_check(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped on first error");
    endtask

    // input byte j lands in output byte 63 - j
    function automatic logic [FLIT_W-1:0] reverse_bytes(input logic [FLIT_W-1:0] d);
        logic [FLIT_W-1:0] r;
        for (int j = 0; j < FLIT_BYTES; j++) begin
            r[FLIT_W-8-8*j +: 8] = d[8*j +: 8];
        end
        return r;
    endfunction

    function automatic logic [FLIT_W-1:0] random_data();
        logic [FLIT_W-1:0] d;
        for (int w = 0; w < FLIT_W / 32; w++) begin
            d[32*w +: 32] = $urandom;
        end
        return d;
    endfunction

    task automatic track_inputs();
        meta_acc = in_meta_valid && in_meta_ready;
        flit_acc = in_valid && in_ready;
        if (meta_acc) begin
            assert (!meta_held) else fail_check("metadata accepted before the packet ended");
            meta_held   = 1'b1;
            held_pkt_id = in_meta_pkt_queue_id;
            held_dsc_id = in_meta_dsc_queue_id;
        end
        if (in_valid && !in_ready && meta_held) begin
            saw_in_stall = 1'b1;
        end
        if (flit_acc) begin
            assert (meta_held) else fail_check("flit accepted with no metadata held");
            exp_flits.push_back({in_sop, in_eop, reverse_bytes(in_data)});
            model_flits = in_sop ? 1 : model_flits + 1;
            if (in_eop) begin
                exp_descs.push_back({held_dsc_id[`PDU_APP_IDX_WIDTH-1:0],
                                     held_pkt_id[`PDU_FLOW_IDX_WIDTH-1:0],
                                     16'(model_flits),
                                     16'(model_flits * FLIT_BYTES - int'(in_empty))});
                meta_held = 1'b0;
            end
        end
    endtask

    task automatic track_outputs();
        logic [FLIT_W+1:0] want_f;
        logic [DESC_W-1:0] want_d;
        logic [DESC_W-1:0] got_d;
        if (out_pkt_valid && out_pkt_ready) begin
            assert (exp_flits.size() > 0) else fail_check("flit output with none expected");
            want_f = exp_flits.pop_front();
            assert ({out_pkt_sop, out_pkt_eop, out_pkt_data} == want_f)
                else fail_check($sformatf("flit %0d does not match the model", flits_out));
            flits_out++;
        end
        if (out_dsc_valid && out_dsc_ready) begin
            assert (exp_descs.size() > 0) else fail_check("descriptor output with none expected");
            want_d = exp_descs.pop_front();
            got_d  = {out_dsc_queue_id, out_pkt_queue_id, out_size_flits, out_size_bytes};
            assert (got_d == want_d)
                else fail_check($sformatf("descriptor %0d is %h, expected %h",
                                          descs_out, got_d, want_d));
            descs_out++;
        end
    endtask

    task automatic drive_flits();
        logic last;
        if (flit_acc) begin
            drv_flit++;
            if (drv_flit == pkt_len[drv_pkt]) begin
                drv_flit = 0;
                drv_pkt++;
            end
        end
        if (!in_valid || flit_acc) begin
            if (drv_pkt < NUM_PKTS && $urandom_range(0, 3) != 0) begin
                last = (drv_flit == pkt_len[drv_pkt] - 1);
                in_valid <= 1'b1;
                in_sop   <= (drv_flit == 0);
                in_eop   <= last;
                in_data  <= random_data();
                in_empty <= last ? pkt_empty[drv_pkt] : 6'($urandom_range(0, 63));
            end else begin
                in_valid <= 1'b0;
            end
        end
    endtask

    // metadata may show up well before its first flit
    task automatic drive_meta();
        if (meta_acc) begin
            meta_idx++;
        end
        if (!in_meta_valid || meta_acc) begin
            if (meta_idx < NUM_PKTS && $urandom_range(0, 2) == 0) begin
                in_meta_valid        <= 1'b1;
                in_meta_pkt_queue_id <= pkt_ids[meta_idx];
                in_meta_dsc_queue_id <= dsc_ids[meta_idx];
            end else begin
                in_meta_valid <= 1'b0;
            end
        end
    endtask

    task automatic drive_readys();
        if (stall_left > 0) begin
            stall_left--;
            out_pkt_ready <= 1'b0;
            out_dsc_ready <= 1'b0;
        end else if ($urandom_range(0, 199) == 0) begin
            stall_left = 40 + int'($urandom_range(0, 120));
            out_pkt_ready <= 1'b0;
            out_dsc_ready <= 1'b0;
        end else begin
            out_pkt_ready <= ($urandom_range(0, 3) != 0);
            out_dsc_ready <= ($urandom_range(0, 3) != 0);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            track_inputs();
            track_outputs();
            drive_flits();
            drive_meta();
            drive_readys();
        end
    end

    initial begin
        #((RESET_CYCLES + WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired at %0t ns with %0d of %0d descriptors received",
                 $time, descs_out, NUM_PKTS);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(32'hdbd4_474d));
        for (int p = 0; p < NUM_PKTS; p++) begin
            pkt_ids[p]   = 16'($urandom);
            dsc_ids[p]   = 16'($urandom);
            pkt_len[p]   = 1 + int'($urandom_range(0, MAX_FLITS - 1));
            pkt_empty[p] = 6'($urandom_range(0, 63));
            total_flits += pkt_len[p];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!in_ready && in_meta_ready) else fail_check("wrong input readys after reset");
        while (descs_out < NUM_PKTS || flits_out < total_flits) begin
            @(posedge clk);
        end
        // any extra output in these cycles finds the model empty
        repeat (4) @(posedge clk);
        assert (saw_in_stall) else fail_check("in_ready never fell under back-pressure");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
